//--- tb.f
verilog/linedbl_pkg.sv
verilog/line_writer.sv
verilog/line_buffer.sv
verilog/line_reader.sv
verilog/scanline_out.sv
verilog/linedbl_top.sv
test/tb_clkgen.sv
test/linedbl_assertions.sv
test/linedbl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= linedbl_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the testbench printed its pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST OK$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- test/linedbl_tb.sv
`timescale 1ns/1ns

module linedbl_tb import linedbl_pkg::*; ();

  localparam int NUM_PAGES    = 4;
  localparam int MAX_SAMPLES  = 64;
  localparam int HSTART       = 4;
  localparam int HSTOP        = 12;
  localparam int HS_WIDTH     = 3;
  localparam int VS_LINES     = 2;
  localparam int WIN          = HSTOP - HSTART;
  localparam int CLK_PERIOD   = 4;
  localparam int LINE_SAMPLES = 24;
  localparam int LINE_CYCLES  = 2 * LINE_SAMPLES;
  localparam int LONG_SAMPLES = 70;
  // bypass 4, doubling 13, scanline 12, overflow about 15 line lengths
  localparam int TOTAL_LINES  = 44;
  localparam int TIMEOUT_NS   = (TOTAL_LINES * LINE_CYCLES * 5 / 4 + 20) * CLK_PERIOD;

  typedef logic [WIN*24-1:0] line_t;

  logic     VCLK_Tx;
  logic     nVRST_Tx;
  logic     vsync_n_i;
  logic     hsync_n_i;
  rgb_t     rgb_i;
  logic     linedbl_en_i;
  logic     sl_en_i;
  sl_str_t  sl_str_i;
  color_o_t r_o;
  color_o_t g_o;
  color_o_t b_o;
  logic     hsync_n_o;
  logic     vsync_n_o;

  integer seed = 75;
  int     line_id = 1;
  int     err_cnt = 0;
  rgb_t   pix_mem [128][WIN];

  // output line capture
  bit     collect;
  bit     check_black;
  bit     in_line;
  int     off;
  line_t  cur;
  line_t  lines[$];
  logic   hs_prev = 1'b1;
  logic   vs_prev = 1'b1;
  int     vs_len;
  int     vs_hs;
  int     vs_lens[$];
  int     vs_hs_cnt[$];

  tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(10)) tb_clkgen_i (
    .clk_o  (VCLK_Tx),
    .rst_n_o(nVRST_Tx)
  );

  linedbl_top #(
    .NUM_PAGES  (NUM_PAGES),
    .MAX_SAMPLES(MAX_SAMPLES),
    .HSTART     (HSTART),
    .HSTOP      (HSTOP),
    .HS_WIDTH   (HS_WIDTH),
    .VS_LINES   (VS_LINES)
  ) linedbl_top_i (.*);

  ////////////////////////////////////////////////////////////////////////////
  // reference model and helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic color_o_t expand7(logic [6:0] c);
    return {c, c[6]};
  endfunction

  function automatic logic [6:0] dim7(logic [6:0] c, int s);
    int v;
    v = (int'(c) * (16 - s)) >>> 4;
    return 7'(v);
  endfunction

  function automatic logic [23:0] expected_out(rgb_t p, bit dim, int s);
    logic [6:0] c [3];
    for (int k = 0; k < 3; k++) begin
      c[k] = p[20-7*k -: 7];
      if (dim) begin
        c[k] = dim7(c[k], s);
      end
    end
    return {expand7(c[0]), expand7(c[1]), expand7(c[2])};
  endfunction

  function automatic logic [6:0] rand7();
    logic [6:0] v;
    v = 7'($random(seed));
    if (v == 7'd0) begin
      v = 7'd1;
    end
    return v;
  endfunction

  task automatic stop_on_error();
    err_cnt++;
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_val(string test, string what, logic [23:0] exp, logic [23:0] act);
    assert (exp === act) else begin
      $display("[FAIL] %s: %s expected %0h actual %0h", test, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic tick();
    @(posedge VCLK_Tx);
    #1;
  endtask

  // one input line, each sample held for two clocks
  task automatic send_line(input bit vs_low, input int nsamp);
    rgb_t p;
    for (int s = 0; s < nsamp; s++) begin
      if (s >= HSTART && s < HSTOP) begin
        p = {line_id[6:0], 7'(s - HSTART + 1), rand7()};
        pix_mem[line_id][s-HSTART] = p;
      end else begin
        p = {rand7(), rand7(), rand7()};
      end
      hsync_n_i = (s >= 2);
      vsync_n_i = !vs_low;
      rgb_i     = p;
      tick();
      tick();
    end
    line_id = (line_id == 120) ? 1 : line_id + 1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output monitor, sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge VCLK_Tx) begin
    if (collect) begin
      if (hs_prev && !hsync_n_o) begin
        if (in_line) begin
          lines.push_back(cur);
        end
        in_line = 1'b1;
        off     = 0;
        cur     = '0;
        if (!vsync_n_o) begin
          vs_hs++;
        end
      end
      if (in_line) begin
        if (off >= HSTART && off < HSTOP) begin
          cur[(off-HSTART)*24 +: 24] = {r_o, g_o, b_o};
        end
        off++;
      end
      if (!vsync_n_o) begin
        vs_len++;
      end else if (!vs_prev) begin
        vs_lens.push_back(vs_len);
        vs_hs_cnt.push_back(vs_hs);
        vs_len = 0;
        vs_hs  = 0;
      end
    end else begin
      in_line = 1'b0;
      vs_len  = 0;
      vs_hs   = 0;
    end
    if (check_black && ({r_o, g_o, b_o} != 24'd0 || !hsync_n_o)) begin
      $display("overflow: video output is not blank while readout is stopped");
      stop_on_error();
    end
    hs_prev = hsync_n_o;
    vs_prev = vsync_n_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_test();
    repeat (2) @(negedge VCLK_Tx);
    check_val("reset", "hsync_n_o", 24'd1, 24'(hsync_n_o));
    check_val("reset", "vsync_n_o", 24'd1, 24'(vsync_n_o));
    check_val("reset", "rgb", 24'd0, {r_o, g_o, b_o});
    wait (nVRST_Tx);
    tick();
    @(negedge VCLK_Tx);
    check_val("reset", "hsync_n_o after release", 24'd1, 24'(hsync_n_o));
    check_val("reset", "rgb after release", 24'd0, {r_o, g_o, b_o});
    tick();
  endtask

  task automatic bypass_test();
    rgb_t in_pix;
    logic in_hs;
    logic in_vs;
    linedbl_en_i = 1'b0;
    sl_en_i      = 1'b0;
    fork
      repeat (4) send_line(1'b0, LINE_SAMPLES);
      repeat (4 * LINE_CYCLES - 1) begin
        @(posedge VCLK_Tx);
        in_pix = rgb_i;
        in_hs  = hsync_n_i;
        in_vs  = vsync_n_i;
        @(negedge VCLK_Tx);
        check_val("bypass", "rgb", expected_out(in_pix, 1'b0, 0), {r_o, g_o, b_o});
        check_val("bypass", "hsync_n_o", 24'(in_hs), 24'(hsync_n_o));
        check_val("bypass", "vsync_n_o", 24'(in_vs), 24'(vsync_n_o));
      end
    join
  endtask

  // vsync line, then nlines lines, with another vsync at line vs_at
  task automatic frame_check(string test, bit sl_on, int s, int nlines, int vs_at);
    int    need;
    int    id;
    int    prev_id;
    int    min_vs;
    line_t a;
    line_t b;
    sl_en_i      = sl_on;
    sl_str_i     = sl_str_t'(s);
    linedbl_en_i = 1'b1;
    lines.delete();
    vs_lens.delete();
    vs_hs_cnt.delete();
    collect = 1'b1;
    send_line(1'b1, LINE_SAMPLES);
    for (int n = 0; n < nlines; n++) begin
      send_line(n == vs_at, LINE_SAMPLES);
    end
    collect = 1'b0;
    need    = 2 * (nlines - 5);
    if (lines.size() < need) begin
      $display("%s: too few output lines, wanted %0d and saw %0d", test, need, lines.size());
      stop_on_error();
    end
    prev_id = 0;
    for (int k = 0; k < need; k += 2) begin
      a  = lines[k];
      b  = lines[k+1];
      id = int'(a[23:17]);
      if (k > 0) begin
        check_val(test, "line id", 24'((prev_id == 120) ? 1 : prev_id + 1), 24'(id));
      end
      for (int i = 0; i < WIN; i++) begin
        check_val(test, "first copy pixel", expected_out(pix_mem[id][i], 1'b0, s),
                  a[i*24 +: 24]);
        check_val(test, "second copy pixel", expected_out(pix_mem[id][i], sl_on, s),
                  b[i*24 +: 24]);
      end
      prev_id = id;
    end
    min_vs = (vs_at >= 0) ? 2 : 1;
    if (vs_lens.size() < min_vs) begin
      $display("%s: expected %0d output vsync pulses, saw %0d", test, min_vs, vs_lens.size());
      stop_on_error();
    end
    for (int j = 0; j < vs_lens.size(); j++) begin
      check_val(test, "vsync low cycles", 24'(VS_LINES * LINE_SAMPLES), 24'(vs_lens[j]));
      check_val(test, "hsync falls in vsync", 24'(VS_LINES), 24'(vs_hs_cnt[j]));
    end
  endtask

  task automatic scanline_test();
    // one bypass line drops the reader back to idle
    linedbl_en_i = 1'b0;
    send_line(1'b0, LINE_SAMPLES);
    frame_check("scanline", 1'b1, 5, 10, -1);
  endtask

  task automatic overflow_test();
    send_line(1'b0, LONG_SAMPLES);
    check_black = 1'b1;
    repeat (3) send_line(1'b0, LINE_SAMPLES);
    check_black = 1'b0;
    frame_check("overflow", 1'b0, 0, 8, -1);
  endtask

  initial begin
    vsync_n_i    = 1'b1;
    hsync_n_i    = 1'b1;
    rgb_i        = '0;
    linedbl_en_i = 1'b0;
    sl_en_i      = 1'b0;
    sl_str_i     = '0;
    reset_test();
    bypass_test();
    frame_check("doubling", 1'b0, 0, 12, 6);
    scanline_test();
    overflow_test();
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- test/linedbl_assertions.sv
`timescale 1ns/1ns

module linedbl_assertions import linedbl_pkg::*; #(
  parameter int HS_WIDTH = 3,
  parameter int WIN      = 8
) (
  input logic     VCLK_Tx,
  input logic     nVRST_Tx,
  input logic     linedbl_en_i,
  input logic     overflow_i,
  input logic     wr_en_i,
  input hcnt_t    wr_addr_i,
  input color_o_t r_i,
  input color_o_t g_i,
  input color_o_t b_i,
  input logic     hsync_n_i,
  input logic     vsync_n_i
);

  // low cycles of the current output hsync pulse
  int hs_low;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      hs_low <= 0;
    end else if (!hsync_n_i) begin
      hs_low <= hs_low + 1;
    end else begin
      hs_low <= 0;
    end
  end

  // a stopped readout may cut a pulse short
  hs_width_a: assert property (@(posedge VCLK_Tx)
    disable iff (!nVRST_Tx || !linedbl_en_i || overflow_i)
    $rose(hsync_n_i) |-> hs_low == HS_WIDTH)
    else $error("doubled hsync pulse is not %0d cycles long", HS_WIDTH);

  reset_quiet_a: assert property (@(posedge VCLK_Tx)
    !nVRST_Tx |-> hsync_n_i && vsync_n_i && r_i == '0 && g_i == '0 && b_i == '0)
    else $error("outputs are not idle during reset");

  wr_addr_a: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    wr_en_i |-> wr_addr_i < hcnt_t'(WIN))
    else $error("line buffer write address out of the active window");

endmodule

bind linedbl_top linedbl_assertions #(
  .HS_WIDTH(HS_WIDTH),
  .WIN     (HSTOP - HSTART)
) linedbl_assertions_i (
  .VCLK_Tx     (VCLK_Tx),
  .nVRST_Tx    (nVRST_Tx),
  .linedbl_en_i(linedbl_en_i),
  .overflow_i  (overflow),
  .wr_en_i     (wr_en),
  .wr_addr_i   (wr_addr),
  .r_i         (r_o),
  .g_i         (g_o),
  .b_i         (b_o),
  .hsync_n_i   (hsync_n_o),
  .vsync_n_i   (vsync_n_o)
);

//--- test/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // short high pulse first, so the reset has a real falling edge
  initial begin
    rst_n_o = 1'b1;
    #1 rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

//--- verilog/linedbl_top.sv
`timescale 1ns/1ns

module linedbl_top import linedbl_pkg::*; #(
  parameter int NUM_PAGES   = 4,
  parameter int MAX_SAMPLES = 1600,
  parameter int HSTART      = 120,
  parameter int HSTOP       = 760,
  parameter int HS_WIDTH    = 64,
  parameter int VS_LINES    = 6
) (
  input  logic     VCLK_Tx,
  input  logic     nVRST_Tx,
  input  logic     vsync_n_i,
  input  logic     hsync_n_i,
  input  rgb_t     rgb_i,
  input  logic     linedbl_en_i,
  input  logic     sl_en_i,
  input  sl_str_t  sl_str_i,
  output color_o_t r_o,
  output color_o_t g_o,
  output color_o_t b_o,
  output logic     hsync_n_o,
  output logic     vsync_n_o
);

  // write side
  logic  wr_en;
  page_t wr_page;
  hcnt_t wr_addr;
  rgb_t  wr_data;
  logic  frame_start;
  logic  line_start;
  hcnt_t line_width;
  logic  overflow;

  // read side
  page_t rd_page;
  hcnt_t rd_addr;
  rgb_t  rd_data;
  logic  pix_valid;
  logic  draw_sl;
  logic  hsync_n;
  logic  vsync_n;
  logic  run;

  line_writer #(
    .NUM_PAGES  (NUM_PAGES),
    .MAX_SAMPLES(MAX_SAMPLES),
    .HSTART     (HSTART),
    .HSTOP      (HSTOP)
  ) line_writer_i (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .vsync_n_i    (vsync_n_i),
    .hsync_n_i    (hsync_n_i),
    .rgb_i        (rgb_i),
    .wr_en_o      (wr_en),
    .wr_page_o    (wr_page),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .frame_start_o(frame_start),
    .line_start_o (line_start),
    .line_width_o (line_width),
    .overflow_o   (overflow)
  );

  line_buffer #(
    .NUM_PAGES  (NUM_PAGES),
    .MAX_SAMPLES(MAX_SAMPLES),
    .HSTART     (HSTART),
    .HSTOP      (HSTOP)
  ) line_buffer_i (
    .VCLK_Tx  (VCLK_Tx),
    .wr_en_i  (wr_en),
    .wr_page_i(wr_page),
    .wr_addr_i(wr_addr),
    .wr_data_i(wr_data),
    .rd_page_i(rd_page),
    .rd_addr_i(rd_addr),
    .rd_data_o(rd_data)
  );

  line_reader #(
    .NUM_PAGES(NUM_PAGES),
    .HSTART   (HSTART),
    .HSTOP    (HSTOP),
    .HS_WIDTH (HS_WIDTH),
    .VS_LINES (VS_LINES)
  ) line_reader_i (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .linedbl_en_i (linedbl_en_i),
    .sl_en_i      (sl_en_i),
    .frame_start_i(frame_start),
    .line_start_i (line_start),
    .wr_page_i    (wr_page),
    .line_width_i (line_width),
    .overflow_i   (overflow),
    .rd_page_o    (rd_page),
    .rd_addr_o    (rd_addr),
    .pix_valid_o  (pix_valid),
    .draw_sl_o    (draw_sl),
    .hsync_n_o    (hsync_n),
    .vsync_n_o    (vsync_n),
    .run_o        (run)
  );

  scanline_out scanline_out_i (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .linedbl_en_i (linedbl_en_i),
    .sl_str_i     (sl_str_i),
    .rgb_i        (rgb_i),
    .vsync_n_i    (vsync_n_i),
    .hsync_n_i    (hsync_n_i),
    .rd_data_i    (rd_data),
    .pix_valid_i  (pix_valid),
    .draw_sl_i    (draw_sl),
    .hsync_n_i_dbl(hsync_n),
    .vsync_n_i_dbl(vsync_n),
    .run_i        (run),
    .r_o          (r_o),
    .g_o          (g_o),
    .b_o          (b_o),
    .hsync_n_o    (hsync_n_o),
    .vsync_n_o    (vsync_n_o)
  );

endmodule

//--- verilog/scanline_out.sv
`timescale 1ns/1ns

module scanline_out import linedbl_pkg::*; (
  input  logic     VCLK_Tx,
  input  logic     nVRST_Tx,
  input  logic     linedbl_en_i,
  input  sl_str_t  sl_str_i,
  input  rgb_t     rgb_i,
  input  logic     vsync_n_i,
  input  logic     hsync_n_i,
  input  rgb_t     rd_data_i,
  input  logic     pix_valid_i,
  input  logic     draw_sl_i,
  input  logic     hsync_n_i_dbl,
  input  logic     vsync_n_i_dbl,
  input  logic     run_i,
  output color_o_t r_o,
  output color_o_t g_o,
  output color_o_t b_o,
  output logic     hsync_n_o,
  output logic     vsync_n_o
);

  color_i_t buf_r;
  color_i_t buf_g;
  color_i_t buf_b;
  rgb_t     pix;

  assign buf_r = rd_data_i[3*COLOR_W_I-1 -: COLOR_W_I];
  assign buf_g = rd_data_i[2*COLOR_W_I-1 -: COLOR_W_I];
  assign buf_b = rd_data_i[COLOR_W_I-1:0];

  // pixel source, black outside the active window of the doubled picture
  always_comb begin
    pix = '0;
    if (!linedbl_en_i) begin
      pix = rgb_i;
    end else if (pix_valid_i && run_i) begin
      if (draw_sl_i) begin
        pix = {darken(buf_r, sl_str_i), darken(buf_g, sl_str_i), darken(buf_b, sl_str_i)};
      end else begin
        pix = rd_data_i;
      end
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      r_o       <= '0;
      g_o       <= '0;
      b_o       <= '0;
      hsync_n_o <= 1'b1;
      vsync_n_o <= 1'b1;
    end else begin
      r_o       <= widen_color(pix[3*COLOR_W_I-1 -: COLOR_W_I]);
      g_o       <= widen_color(pix[2*COLOR_W_I-1 -: COLOR_W_I]);
      b_o       <= widen_color(pix[COLOR_W_I-1:0]);
      hsync_n_o <= linedbl_en_i ? hsync_n_i_dbl : hsync_n_i;
      vsync_n_o <= linedbl_en_i ? vsync_n_i_dbl : vsync_n_i;
    end
  end

endmodule

//--- verilog/line_reader.sv
`timescale 1ns/1ns

module line_reader import linedbl_pkg::*; #(
  parameter int NUM_PAGES = 4,
  parameter int HSTART    = 120,
  parameter int HSTOP     = 760,
  parameter int HS_WIDTH  = 64,
  parameter int VS_LINES  = 6
) (
  input  logic  VCLK_Tx,
  input  logic  nVRST_Tx,
  input  logic  linedbl_en_i,
  input  logic  sl_en_i,
  input  logic  frame_start_i,
  input  logic  line_start_i,
  input  page_t wr_page_i,
  input  hcnt_t line_width_i,
  input  logic  overflow_i,
  output page_t rd_page_o,
  output hcnt_t rd_addr_o,
  output logic  pix_valid_o,
  output logic  draw_sl_o,
  output logic  hsync_n_o,
  output logic  vsync_n_o,
  output logic  run_o
);

  typedef enum logic [1:0] {IDLE, ARMED, RUN} rd_state_t;

  rd_state_t state;
  hcnt_t     ocnt;
  logic      rep;
  hcnt_t     vcnt;
  logic      vs_pend;
  logic      running;
  logic      run_start;
  logic      line_end;
  logic      line_wrap;
  logic      in_window;

  assign running = (state == RUN);

  // start once half the pages hold complete lines
  assign run_start = (state == ARMED) && linedbl_en_i && line_start_i &&
                     (wr_page_i == page_t'(NUM_PAGES / 2));

  assign line_end  = running && (hcnt_t'(ocnt + 1'b1) >= line_width_i);
  assign line_wrap = run_start | line_end;

  assign in_window = running && (ocnt >= hcnt_t'(HSTART)) && (ocnt < hcnt_t'(HSTOP));
  assign rd_addr_o = in_window ? ocnt - hcnt_t'(HSTART) : '0;

  ////////////////////////////////////////////////////////////////////////////
  // readout control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (frame_start_i && linedbl_en_i) begin
            state <= ARMED;
          end
        end
        ARMED: begin
          if (!linedbl_en_i) begin
            state <= IDLE;
          end else if (run_start) begin
            state <= RUN;
          end
        end
        RUN: begin
          // stays down until the next frame
          if (overflow_i || !linedbl_en_i) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // cycle, repeat and page counters
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      ocnt      <= '0;
      rep       <= 1'b0;
      rd_page_o <= '0;
    end else begin
      if (line_wrap) begin
        ocnt <= '0;
      end else if (running) begin
        ocnt <= ocnt + 1'b1;
      end
      if (run_start) begin
        rep       <= 1'b0;
        rd_page_o <= '0;
      end else if (line_end) begin
        rep <= ~rep;
        // second copy done, move on
        if (rep) begin
          if (rd_page_o == page_t'(NUM_PAGES - 1)) begin
            rd_page_o <= '0;
          end else begin
            rd_page_o <= rd_page_o + 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // vertical sync, restarted at the first output line after a frame start
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vcnt    <= hcnt_t'(VS_LINES);
      vs_pend <= 1'b0;
    end else begin
      if (line_wrap) begin
        if (vs_pend) begin
          vcnt <= '0;
        end else if (vcnt < hcnt_t'(VS_LINES)) begin
          vcnt <= vcnt + 1'b1;
        end
      end
      if (frame_start_i) begin
        vs_pend <= 1'b1;
      end else if (line_wrap) begin
        vs_pend <= 1'b0;
      end
    end
  end

  // delayed by one cycle to line up with rd_data
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      pix_valid_o <= 1'b0;
      draw_sl_o   <= 1'b0;
      hsync_n_o   <= 1'b1;
      vsync_n_o   <= 1'b1;
      run_o       <= 1'b0;
    end else begin
      pix_valid_o <= in_window;
      draw_sl_o   <= running && sl_en_i && rep;
      hsync_n_o   <= !(running && (ocnt < hcnt_t'(HS_WIDTH)));
      vsync_n_o   <= !(running && (vcnt < hcnt_t'(VS_LINES)));
      run_o       <= running;
    end
  end

endmodule

//--- verilog/line_buffer.sv
`timescale 1ns/1ns

module line_buffer import linedbl_pkg::*; #(
  parameter int NUM_PAGES   = 4,
  parameter int MAX_SAMPLES = 1600,
  parameter int HSTART      = 120,
  parameter int HSTOP       = 760
) (
  input  logic  VCLK_Tx,
  input  logic  wr_en_i,
  input  page_t wr_page_i,
  input  hcnt_t wr_addr_i,
  input  rgb_t  wr_data_i,
  input  page_t rd_page_i,
  input  hcnt_t rd_addr_i,
  output rgb_t  rd_data_o
);

  // one entry per active sample, never more than a full line
  localparam int WIN        = HSTOP - HSTART;
  localparam int PAGE_DEPTH = (WIN < MAX_SAMPLES) ? WIN : MAX_SAMPLES;
  localparam int AW         = (PAGE_DEPTH > 1) ? $clog2(PAGE_DEPTH) : 1;

  rgb_t          mem [NUM_PAGES][PAGE_DEPTH];
  logic [AW-1:0] wa;
  logic [AW-1:0] ra;

  assign wa = wr_addr_i[AW-1:0];
  assign ra = rd_addr_i[AW-1:0];

  always_ff @(posedge VCLK_Tx) begin
    if (wr_en_i) begin
      mem[wr_page_i][wa] <= wr_data_i;
    end
  end

  // registered read, data follows the address by one cycle
  always_ff @(posedge VCLK_Tx) begin
    rd_data_o <= mem[rd_page_i][ra];
  end

endmodule

//--- verilog/line_writer.sv
`timescale 1ns/1ns

module line_writer import linedbl_pkg::*; #(
  parameter int NUM_PAGES   = 4,
  parameter int MAX_SAMPLES = 1600,
  parameter int HSTART      = 120,
  parameter int HSTOP       = 760
) (
  input  logic  VCLK_Tx,
  input  logic  nVRST_Tx,
  input  logic  vsync_n_i,
  input  logic  hsync_n_i,
  input  rgb_t  rgb_i,
  output logic  wr_en_o,
  output page_t wr_page_o,
  output hcnt_t wr_addr_o,
  output rgb_t  wr_data_o,
  output logic  frame_start_o,
  output logic  line_start_o,
  output hcnt_t line_width_o,
  output logic  overflow_o
);

  logic  phase;
  logic  sample;
  logic  hs_d;
  logic  vs_d;
  hcnt_t cnt;
  hcnt_t cur_idx;
  page_t cur_page;
  logic  in_window;

  ////////////////////////////////////////////////////////////////////////////
  // sample phase and sync edges
  ////////////////////////////////////////////////////////////////////////////

  // input video is valid on every second cycle
  assign sample = phase;

  assign line_start_o  = sample & hs_d & ~hsync_n_i;
  assign frame_start_o = sample & vs_d & ~vsync_n_i;

  ////////////////////////////////////////////////////////////////////////////
  // sample index and page selection
  ////////////////////////////////////////////////////////////////////////////

  // the sample that comes with the hsync fall is index 0
  assign cur_idx = line_start_o ? '0 : cnt;

  always_comb begin
    cur_page = wr_page_o;
    if (line_start_o) begin
      if (wr_page_o == page_t'(NUM_PAGES - 1)) begin
        cur_page = '0;
      end else begin
        cur_page = wr_page_o + 1'b1;
      end
    end
  end

  assign in_window = (cur_idx >= hcnt_t'(HSTART)) && (cur_idx < hcnt_t'(HSTOP));

  // counter sticks at max until the next hsync
  assign overflow_o = (cnt == hcnt_t'(MAX_SAMPLES));

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      phase        <= 1'b0;
      hs_d         <= 1'b1;
      vs_d         <= 1'b1;
      cnt          <= '0;
      line_width_o <= '0;
      wr_en_o      <= 1'b0;
      wr_page_o    <= '0;
    end else begin
      phase   <= ~phase;
      wr_en_o <= sample & in_window;
      if (sample) begin
        hs_d      <= hsync_n_i;
        vs_d      <= vsync_n_i;
        wr_page_o <= cur_page;
        // cnt holds the sample count of the line that just ended
        if (line_start_o) begin
          line_width_o <= cnt;
        end
        if (cur_idx == hcnt_t'(MAX_SAMPLES)) begin
          cnt <= cur_idx;
        end else begin
          cnt <= cur_idx + 1'b1;
        end
      end
    end
  end

  // write address and pixel, registered together with wr_en_o
  always_ff @(posedge VCLK_Tx) begin
    if (sample && in_window) begin
      wr_addr_o <= cur_idx - hcnt_t'(HSTART);
    end
    if (sample) begin
      wr_data_o <= rgb_i;
    end
  end

endmodule

//--- verilog/linedbl_pkg.sv
package linedbl_pkg;

  // channel widths at the input and at the output
  localparam int COLOR_W_I = 7;
  localparam int COLOR_W_O = 8;

  // counter widths, sample counter covers up to 1600
  localparam int HCNT_W   = 11;
  localparam int PAGE_W   = 2;
  localparam int SL_STR_W = 4;

  typedef logic [COLOR_W_I-1:0]   color_i_t;
  typedef logic [COLOR_W_O-1:0]   color_o_t;
  // r in the top bits, then g, then b
  typedef logic [3*COLOR_W_I-1:0] rgb_t;
  typedef logic [HCNT_W-1:0]      hcnt_t;
  typedef logic [PAGE_W-1:0]      page_t;
  typedef logic [SL_STR_W-1:0]    sl_str_t;

  // 7 to 8 bits, msb repeated as new lsb so full scale stays full scale
  function automatic color_o_t widen_color(color_i_t c);
    return {c, c[COLOR_W_I-1]};
  endfunction

  // scale by (16 - s) / 16
  function automatic color_i_t darken(color_i_t c, sl_str_t s);
    logic [SL_STR_W:0]           mult;
    logic [COLOR_W_I+SL_STR_W:0] prod;
    mult = 5'd16 - {1'b0, s};
    prod = {{(SL_STR_W+1){1'b0}}, c} * {{COLOR_W_I{1'b0}}, mult};
    return prod[COLOR_W_I+SL_STR_W-1:SL_STR_W];
  endfunction

endpackage
